//--- verilog/st_glue_pkg.sv
/* clock, reset and sample width constants, rtc register indices,
   rtc nibble map and the rtc time word union */
package st_glue_pkg;

	// clocks
	localparam logic [31:0] SYS_CLK_HZ = 32'd32084988; // clk_32, not quite 32 MHz
	localparam logic [31:0] MFP_CLK_HZ = 32'd2457600;  // mfp baud/timer clock

	// reset sequencer
	localparam logic [6:0] RESET_CNT_MAX     = 7'd127;
	localparam logic [6:0] MCU_RESET_ASSERT  = 7'd10; // mcu reset window opens here
	localparam logic [6:0] MCU_RESET_RELEASE = 7'd8;  // and closes below this

	// sample widths
	localparam int YM_W  = 10;
	localparam int DMA_W = 8;
	localparam int MIX_W = 15;

	// unsigned sample midpoints
	localparam logic [YM_W-1:0]  YM_MID  = 10'h200;
	localparam logic [DMA_W-1:0] DMA_MID = 8'h80;

	// rtc bus
	localparam int RTC_ADDR_W  = 4; // register index, paddr[5:2]
	localparam int RTC_DATA_W  = 4; // everything is a nibble
	localparam int RTC_PADDR_W = 6;

	localparam logic [RTC_ADDR_W-1:0] RTC_REG_YEAR  = 4'd12;
	localparam logic [RTC_ADDR_W-1:0] RTC_REG_BANK  = 4'd13; // mode reg
	localparam logic [RTC_ADDR_W-1:0] RTC_REG_TEST  = 4'd14;
	localparam logic [RTC_ADDR_W-1:0] RTC_REG_RESET = 4'd15;

	// bank 0 register -> nibble of the time word, regs 11 downto 0
	localparam logic [11:0][3:0] RTC_NIBBLE_MAP = {
		4'd11, 4'd9, 4'd8, 4'd7, 4'd6, 4'd12,
		4'd5, 4'd4, 4'd3, 4'd2, 4'd1, 4'd0
	};

	typedef struct packed {
		logic [3:0] weekday;
		logic [3:0] year_t;
		logic [3:0] year_u;
		logic [3:0] month_t;
		logic [3:0] month_u;
		logic [3:0] day_t;
		logic [3:0] day_u;
		logic [3:0] hour_t;
		logic [3:0] hour_u;
		logic [3:0] min_t;
		logic [3:0] min_u;
		logic [3:0] sec_t;
		logic [3:0] sec_u;
	} rtc_bcd_t;

	// same 52 bits, either as bcd fields or as 13 nibbles
	typedef union packed {
		logic [12:0][3:0] nib;
		rtc_bcd_t         bcd;
	} rtc_time_u;

endpackage

//--- verilog/st_reset_seq.sv
/* reset counter, system and peripheral reset,
   memory controller reset window */
`timescale 1ns/1ps

module st_reset_seq (
	input  logic clk_32,
	input  logic xsint,          // power-on reset, active low
	input  logic ext_reset_n_i,  // reset button
	input  logic cpu_reset_n_i,  // cpu RESET instruction output
	output logic reset_o,
	output logic periph_reset_o,
	output logic mcu_reset_n_o
);

	logic [6:0] reset_cnt;
	logic       cpu_reset_n_d; // for edge detect

	// counts down to zero, reload while the button is held
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			reset_cnt <= st_glue_pkg::RESET_CNT_MAX;
		end else if (!ext_reset_n_i) begin
			reset_cnt <= st_glue_pkg::RESET_CNT_MAX;
		end else if (reset_cnt != 7'd0) begin
			reset_cnt <= reset_cnt - 7'd1;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			reset_o        <= 1'b1;
			periph_reset_o <= 1'b1;
			cpu_reset_n_d  <= 1'b1;
		end else begin
			reset_o        <= reset_cnt != 7'd0;      // registered, one clock behind count
			periph_reset_o <= reset_o | ~cpu_reset_n_i; // cpu reset also clears peripherals
			cpu_reset_n_d  <= cpu_reset_n_i;
		end
	end

	// the mcu is only pulsed, its clocks feed the sdram side
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mcu_reset_n_o <= 1'b1;
		end else begin
			if (reset_cnt == st_glue_pkg::MCU_RESET_ASSERT)
				mcu_reset_n_o <= 1'b0; // window opens
			else if (reset_cnt < st_glue_pkg::MCU_RESET_RELEASE)
				mcu_reset_n_o <= 1'b1;
			// cpu RESET instruction, falling edge
			if (!cpu_reset_n_i && cpu_reset_n_d)
				mcu_reset_n_o <= 1'b0;
		end
	end

endmodule

//--- verilog/mfp_clk_gen.sv
/* fractional divider, 2.4576 MHz mfp clock from clk_32 */
`timescale 1ns/1ps

module mfp_clk_gen (
	input  logic clk_32,
	input  logic xsint,
	output logic clk_mfp_o
);

	logic [31:0] acc;       // phase accumulator
	logic [31:0] half_sys;  // toggle threshold
	logic [31:0] acc_dec;   // amount removed on a toggle
	logic        wrap;

	assign half_sys = st_glue_pkg::SYS_CLK_HZ / 32'd2;
	assign acc_dec  = half_sys - st_glue_pkg::MFP_CLK_HZ;
	assign wrap     = acc >= half_sys;

	// two toggles per mfp period, so compare against half the system clock
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc       <= 32'd0;
			clk_mfp_o <= 1'b0;
		end else if (!wrap) begin
			acc <= acc + st_glue_pkg::MFP_CLK_HZ;
		end else begin
			acc       <= acc - acc_dec; // keep the remainder, no drift
			clk_mfp_o <= ~clk_mfp_o;
		end
	end

endmodule

//--- verilog/snd_irq_delay.sv
/* 2 MHz enable, eight stage sound interrupt delay,
   mfp timer a and gpio 7 levels */
`timescale 1ns/1ps

module snd_irq_delay (
	input  logic clk_32,
	input  logic xsint,
	input  logic ste_i,
	input  logic mono_detect_i,   // low for monochrome
	input  logic dma_snd_int_n_i, // dma sound end of frame
	output logic mfp_timer_a_o,
	output logic mfp_io7_o
);

	logic [3:0] div_cnt;
	logic       clk_2_en;  // one clock in 16
	logic [7:0] delay_q;   // 74ls164 shift register
	logic       clr_n;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			div_cnt  <= 4'd0;
			clk_2_en <= 1'b0;
		end else begin
			clk_2_en <= div_cnt == 4'd0;
			div_cnt  <= div_cnt + 4'd1;
		end
	end

	// the '164 clear pin is the interrupt itself
	assign clr_n = xsint & dma_snd_int_n_i;

	always_ff @(posedge clk_32 or negedge clr_n) begin
		if (!clr_n)
			delay_q <= 8'h00;
		else if (clk_2_en)
			delay_q <= {delay_q[6:0], dma_snd_int_n_i};
	end

	// st has no dma sound, timer a sees an idle printer busy line
	assign mfp_timer_a_o = ste_i ? delay_q[7] : 1'b1;
	assign mfp_io7_o     = mono_detect_i ^ (ste_i & dma_snd_int_n_i); // undelayed here

endmodule

//--- verilog/rtc_rp5c15.sv
/* rp5c15 real time clock register file on apb,
   bank select and bank 1 nibble ram */
`timescale 1ns/1ps

module rtc_rp5c15 (
	input  logic                                  clk_32,
	input  logic                                  xsint,
	input  logic                                  periph_reset_i,
	input  st_glue_pkg::rtc_time_u                rtc_time_i,
	input  logic                                  psel_i,
	input  logic                                  penable_i,
	input  logic                                  pwrite_i,
	input  logic [st_glue_pkg::RTC_PADDR_W-1:0]   paddr_i,
	input  logic [st_glue_pkg::RTC_DATA_W-1:0]    pwdata_i,
	output logic [st_glue_pkg::RTC_DATA_W-1:0]    prdata_o,
	output logic                                  pready_o,
	output logic                                  pslverr_o
);

	logic [st_glue_pkg::RTC_ADDR_W-1:0] reg_idx;
	logic                               wr_en;
	logic                               bank;     // mode reg bit 0
	logic [st_glue_pkg::RTC_DATA_W-1:0] year_fix;
	logic [st_glue_pkg::RTC_DATA_W-1:0] rd_data;

	// bank 1 scratch nibbles
	logic [st_glue_pkg::RTC_DATA_W-1:0] ram [16];

	assign reg_idx = paddr_i[5:2]; // word addressed
	assign wr_en   = psel_i & penable_i & pwrite_i; // access phase only

	// gemdos counts years from 1980
	assign year_fix = rtc_time_i.bcd.year_u + 4'd2;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			bank <= 1'b0;
		else if (periph_reset_i)
			bank <= 1'b0;
		else if (wr_en && reg_idx == st_glue_pkg::RTC_REG_BANK)
			bank <= pwdata_i[0];
	end

	// test and reset regs land in the ram too, they read back fixed anyway
	always_ff @(posedge clk_32) begin
		if (wr_en && reg_idx != st_glue_pkg::RTC_REG_BANK)
			ram[reg_idx] <= pwdata_i;
	end

	always_comb begin
		case (reg_idx)
			st_glue_pkg::RTC_REG_BANK:  rd_data = {3'b100, bank}; // timer enable always set
			st_glue_pkg::RTC_REG_TEST:  rd_data = 4'h0;
			st_glue_pkg::RTC_REG_RESET: rd_data = 4'hc;
			st_glue_pkg::RTC_REG_YEAR:  rd_data = bank ? ram[reg_idx] : year_fix;
			default: begin
				// regs 0 to 11
				if (bank)
					rd_data = ram[reg_idx];
				else
					rd_data = rtc_time_i.nib[st_glue_pkg::RTC_NIBBLE_MAP[reg_idx]];
			end
		endcase
		// no valid time from the io controller, hide the chip
		if (rtc_time_i == '0)
			rd_data = 4'hf;
	end

	assign prdata_o  = rd_data;
	assign pready_o  = 1'b1; // zero wait states
	assign pslverr_o = 1'b0;

endmodule

//--- verilog/audio_mix.sv
/* ym2149 and dma sound sample mixer, 15 bit stereo out */
`timescale 1ns/1ps

module audio_mix (
	input  logic                          clk_32,
	input  logic                          xsint,
	input  logic [st_glue_pkg::YM_W-1:0]  ym_sample_i,
	input  logic [st_glue_pkg::DMA_W-1:0] dma_snd_l_i,
	input  logic [st_glue_pkg::DMA_W-1:0] dma_snd_r_i,
	output logic [st_glue_pkg::MIX_W-1:0] audio_l_o,
	output logic [st_glue_pkg::MIX_W-1:0] audio_r_o
);

	logic [st_glue_pkg::YM_W-1:0]  ym_s;    // two's complement
	logic [st_glue_pkg::DMA_W-1:0] dma_l_s;
	logic [st_glue_pkg::DMA_W-1:0] dma_r_s;
	logic [st_glue_pkg::MIX_W-1:0] ym_w;    // widened to mix width
	logic [st_glue_pkg::MIX_W-1:0] dma_l_w;
	logic [st_glue_pkg::MIX_W-1:0] dma_r_w;

	assign ym_s    = ym_sample_i - st_glue_pkg::YM_MID;
	assign dma_l_s = dma_snd_l_i - st_glue_pkg::DMA_MID;
	assign dma_r_s = dma_snd_r_i - st_glue_pkg::DMA_MID;

	// repeat the top bits at the bottom so full scale stays full scale
	assign ym_w    = {ym_s[9], ym_s, ym_s[9:6]};
	assign dma_l_w = {dma_l_s[7], dma_l_s, dma_l_s[7:2]};
	assign dma_r_w = {dma_r_s[7], dma_r_s, dma_r_s[7:2]};

	// psg is mono, same value on both sides
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			audio_l_o <= ym_w + dma_l_w; // wraps at 15 bits
			audio_r_o <= ym_w + dma_r_w;
		end
	end

endmodule

//--- verilog/st_glue_top.sv
/* clock and reset glue top, reset sequencer, mfp clock,
   sound irq delay, rtc and audio mixer */
`timescale 1ns/1ps

module st_glue_top (
	input  logic                                clk_32,
	input  logic                                xsint,
	input  logic                                ext_reset_n_i,
	input  logic                                cpu_reset_n_i,
	input  logic                                ste_i,
	input  logic                                mono_detect_i,
	input  logic                                dma_snd_int_n_i,
	input  st_glue_pkg::rtc_time_u              rtc_time_i,
	input  logic                                psel_i,
	input  logic                                penable_i,
	input  logic                                pwrite_i,
	input  logic [st_glue_pkg::RTC_PADDR_W-1:0] paddr_i,
	input  logic [st_glue_pkg::RTC_DATA_W-1:0]  pwdata_i,
	output logic [st_glue_pkg::RTC_DATA_W-1:0]  prdata_o,
	output logic                                pready_o,
	output logic                                pslverr_o,
	input  logic [st_glue_pkg::YM_W-1:0]        ym_sample_i,
	input  logic [st_glue_pkg::DMA_W-1:0]       dma_snd_l_i,
	input  logic [st_glue_pkg::DMA_W-1:0]       dma_snd_r_i,
	output logic                                reset_o,
	output logic                                periph_reset_o,
	output logic                                mcu_reset_n_o,
	output logic                                clk_mfp_o,
	output logic                                mfp_timer_a_o,
	output logic                                mfp_io7_o,
	output logic [st_glue_pkg::MIX_W-1:0]       audio_l_o,
	output logic [st_glue_pkg::MIX_W-1:0]       audio_r_o
);

	st_reset_seq st_reset_seq_inst (
		.clk_32         ( clk_32          ),
		.xsint          ( xsint           ),
		.ext_reset_n_i  ( ext_reset_n_i   ),
		.cpu_reset_n_i  ( cpu_reset_n_i   ),
		.reset_o        ( reset_o         ),
		.periph_reset_o ( periph_reset_o  ), // also clears the rtc bank
		.mcu_reset_n_o  ( mcu_reset_n_o   )
	);

	mfp_clk_gen mfp_clk_gen_inst (
		.clk_32    ( clk_32    ),
		.xsint     ( xsint     ),
		.clk_mfp_o ( clk_mfp_o )
	);

	snd_irq_delay snd_irq_delay_inst (
		.clk_32          ( clk_32          ),
		.xsint           ( xsint           ),
		.ste_i           ( ste_i           ),
		.mono_detect_i   ( mono_detect_i   ),
		.dma_snd_int_n_i ( dma_snd_int_n_i ),
		.mfp_timer_a_o   ( mfp_timer_a_o   ),
		.mfp_io7_o       ( mfp_io7_o       )
	);

	rtc_rp5c15 rtc_rp5c15_inst (
		.clk_32         ( clk_32         ),
		.xsint          ( xsint          ),
		.periph_reset_i ( periph_reset_o ),
		.rtc_time_i     ( rtc_time_i     ),
		.psel_i         ( psel_i         ),
		.penable_i      ( penable_i      ),
		.pwrite_i       ( pwrite_i       ),
		.paddr_i        ( paddr_i        ),
		.pwdata_i       ( pwdata_i       ),
		.prdata_o       ( prdata_o       ),
		.pready_o       ( pready_o       ),
		.pslverr_o      ( pslverr_o      )
	);

	audio_mix audio_mix_inst (
		.clk_32      ( clk_32      ),
		.xsint       ( xsint       ),
		.ym_sample_i ( ym_sample_i ),
		.dma_snd_l_i ( dma_snd_l_i ),
		.dma_snd_r_i ( dma_snd_r_i ),
		.audio_l_o   ( audio_l_o   ),
		.audio_r_o   ( audio_r_o   )
	);

endmodule

//--- test/st_glue_props.sv
/* concurrent assertions on apb handshake and reset ordering */
`timescale 1ns/1ps

module st_glue_props (
	input logic clk_32,
	input logic xsint,
	input logic psel_i,
	input logic penable_i,
	input logic pready_o,
	input logic reset_o,
	input logic periph_reset_o
);

	// zero wait state slave
	pready_high: assert property (@(posedge clk_32) disable iff (!xsint) pready_o)
		else $error("pready went low");

	// access cycle only after a setup cycle
	enable_after_setup: assert property (@(posedge clk_32) disable iff (!xsint)
		penable_i |-> $past(psel_i && !penable_i))
		else $error("penable without a setup cycle");

	periph_follows_reset: assert property (@(posedge clk_32) disable iff (!xsint)
		$past(reset_o) |-> periph_reset_o)
		else $error("peripheral reset dropped while system reset was high");

endmodule

bind st_glue_top st_glue_props st_glue_props_inst (.*);

//--- test/st_glue_tb.sv
/* testbench for the st glue top, reset, mfp clock, rtc over apb,
   audio mixer and sound irq delay, rtc and audio driven from a vector file */
`timescale 1ns/1ps

module st_glue_tb;

	logic                                clk_32 = 1'b0;
	logic                                xsint;
	logic                                ext_reset_n_i;
	logic                                cpu_reset_n_i;
	logic                                ste_i;
	logic                                mono_detect_i;
	logic                                dma_snd_int_n_i;
	st_glue_pkg::rtc_time_u              rtc_time_i;
	logic                                psel_i;
	logic                                penable_i;
	logic                                pwrite_i;
	logic [st_glue_pkg::RTC_PADDR_W-1:0] paddr_i;
	logic [st_glue_pkg::RTC_DATA_W-1:0]  pwdata_i;
	logic [st_glue_pkg::RTC_DATA_W-1:0]  prdata_o;
	logic                                pready_o;
	logic                                pslverr_o;
	logic [st_glue_pkg::YM_W-1:0]        ym_sample_i;
	logic [st_glue_pkg::DMA_W-1:0]       dma_snd_l_i;
	logic [st_glue_pkg::DMA_W-1:0]       dma_snd_r_i;
	logic                                reset_o;
	logic                                periph_reset_o;
	logic                                mcu_reset_n_o;
	logic                                clk_mfp_o;
	logic                                mfp_timer_a_o;
	logic                                mfp_io7_o;
	logic [st_glue_pkg::MIX_W-1:0]       audio_l_o;
	logic [st_glue_pkg::MIX_W-1:0]       audio_r_o;

	int tests  = 0;
	int errors = 0;

	st_glue_top st_glue_top_inst (.*);

	always #2 clk_32 = ~clk_32; // 4 ns period

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp === act)
		else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("ok   %s", name);
		else
			$display("FAIL %s", name);
	endtask

	// toggles of the phase accumulator rule over n clocks
	function automatic int mfp_toggles(input int n);
		logic [31:0] acc;
		logic [31:0] half;
		int          t;
		acc  = 32'd0;
		half = st_glue_pkg::SYS_CLK_HZ / 2;
		t    = 0;
		for (int i = 0; i < n; i++) begin
			if (acc < half) begin
				acc = acc + st_glue_pkg::MFP_CLK_HZ;
			end else begin
				acc = acc - (half - st_glue_pkg::MFP_CLK_HZ);
				t++;
			end
		end
		return t;
	endfunction

	task automatic idle_random();
		repeat ($urandom % 3) @(posedge clk_32); // gap between transfers
	endtask

	task automatic apb_write(input logic [3:0] idx, input logic [3:0] data);
		@(posedge clk_32);
		psel_i    <= 1'b1; // setup
		penable_i <= 1'b0;
		pwrite_i  <= 1'b1;
		paddr_i   <= {idx, 2'b00};
		pwdata_i  <= data;
		@(posedge clk_32);
		penable_i <= 1'b1; // access
		@(posedge clk_32);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] idx, output logic [3:0] data);
		int wait_cnt;
		@(posedge clk_32);
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b0;
		paddr_i   <= {idx, 2'b00};
		@(posedge clk_32);
		penable_i <= 1'b1;
		wait_cnt = 0;
		@(negedge clk_32);
		while (!pready_o && wait_cnt < 4) begin // no wait states expected
			@(negedge clk_32);
			wait_cnt++;
		end
		if (!pready_o) begin
			$display("apb read of register %0d got no pready", idx);
			errors++;
		end
		data = prdata_o;
		check_value($sformatf("pslverr_reg%0d", idx), 32'd0, 32'(pslverr_o));
		@(posedge clk_32);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	// reset timing and mcu pulse counted from the xsint release edge
	task automatic reset_check();
		int n;
		int low_cnt;
		int pulses;
		int eb;
		logic mcu_prev;
		eb       = errors;
		n        = 0;
		low_cnt  = 0;
		pulses   = 0;
		mcu_prev = 1'b1;
		while (reset_o && n < 200) begin
			@(posedge clk_32);
			n++;
			@(negedge clk_32);
			if (!mcu_reset_n_o)
				low_cnt++;
			if (mcu_prev && !mcu_reset_n_o)
				pulses++;
			mcu_prev = mcu_reset_n_o;
		end
		if (reset_o) begin
			$display("reset_o still high 200 clocks after release");
			errors++;
		end
		check_value("reset_fall", 32'd1, 32'(n >= 127 && n <= 129));
		check_value("mcu_pulses", 32'd1, 32'(pulses));
		check_value("mcu_low_len", 32'd1, 32'(low_cnt >= 2 && low_cnt <= 3));
		report_test("reset_seq", eb);
	endtask

	task automatic mfp_check();
		int toggles;
		int eb;
		logic prev;
		eb      = errors;
		toggles = 0;
		prev    = clk_mfp_o;
		repeat (20000) begin
			@(posedge clk_32);
			@(negedge clk_32);
			if (clk_mfp_o != prev)
				toggles++;
			prev = clk_mfp_o;
		end
		check_value("mfp_toggles", 32'(mfp_toggles(20000)), 32'(toggles));
		report_test("mfp_clk", eb);
	endtask

	task automatic run_vectors();
		int          fd;
		int          r;
		int          eb;
		string       line;
		string       name;
		string       kind;
		logic [51:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] e1;
		logic [31:0] e2;
		logic [3:0]  rd;
		fd = $fopen("test/st_glue_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open the vector file");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			r = $fgets(line, fd);
			if (line.len() < 3 || line[0] == "#")
				continue; // blank or column notes
			r = $sscanf(line, "%s %s %h %h %h %h %h", name, kind, a, b, c, e1, e2);
			eb = errors;
			if (r != 7) begin
				$display("malformed vector line: %s", line);
				errors++;
			end else if (kind == "time") begin
				@(posedge clk_32);
				rtc_time_i <= a;
			end else if (kind == "wr") begin
				idle_random();
				apb_write(a[3:0], b[3:0]);
			end else if (kind == "rd") begin
				idle_random();
				apb_read(a[3:0], rd);
				check_value(name, e1, 32'(rd));
			end else if (kind == "audio") begin
				@(posedge clk_32);
				ym_sample_i <= a[9:0];
				dma_snd_l_i <= b[7:0];
				dma_snd_r_i <= c[7:0];
				@(posedge clk_32); // mixer registers here
				@(negedge clk_32);
				check_value({name, "_l"}, e1, 32'(audio_l_o));
				check_value({name, "_r"}, e2, 32'(audio_r_o));
			end else begin
				$display("unknown vector kind %s in test %s", kind, name);
				errors++;
			end
			report_test(name, eb);
		end
		$fclose(fd);
	endtask

	task automatic irq_check();
		int   n;
		int   eb;
		logic rose;
		eb = errors;
		@(posedge clk_32);
		dma_snd_int_n_i <= 1'b0;
		@(negedge clk_32);
		check_value("timer_a_clear", 32'd0, 32'(mfp_timer_a_o)); // async clear
		check_value("io7_low_int", 32'd1, 32'(mfp_io7_o));
		repeat (20) @(posedge clk_32);
		dma_snd_int_n_i <= 1'b1;
		n    = 0;
		rose = 1'b0;
		while (!rose && n < 140) begin
			@(posedge clk_32);
			n++;
			@(negedge clk_32);
			rose = mfp_timer_a_o;
		end
		if (!rose) begin
			$display("timer a did not rise within 140 clocks");
			errors++;
		end
		check_value("io7_high_int", 32'd0, 32'(mfp_io7_o));
		// st mode pins timer a high
		@(posedge clk_32);
		ste_i           <= 1'b0;
		mono_detect_i   <= 1'b0;
		dma_snd_int_n_i <= 1'b0;
		repeat (40) begin
			@(negedge clk_32);
			check_value("st_timer_a", 32'd1, 32'(mfp_timer_a_o));
		end
		@(posedge clk_32);
		dma_snd_int_n_i <= 1'b1; // io7 ignores the interrupt in st mode
		@(negedge clk_32);
		check_value("st_io7", 32'd0, 32'(mfp_io7_o));
		report_test("snd_irq", eb);
	endtask

	initial begin
		void'($urandom(32'hc3cacd74));
		xsint           = 1'b0;
		ext_reset_n_i   = 1'b1;
		cpu_reset_n_i   = 1'b1;
		ste_i           = 1'b1;
		mono_detect_i   = 1'b1;
		dma_snd_int_n_i = 1'b1;
		rtc_time_i      = '0;
		psel_i          = 1'b0;
		penable_i       = 1'b0;
		pwrite_i        = 1'b0;
		paddr_i         = '0;
		pwdata_i        = '0;
		ym_sample_i     = 10'h200; // silence
		dma_snd_l_i     = 8'h80;
		dma_snd_r_i     = 8'h80;
		repeat (5) @(posedge clk_32);
		xsint <= 1'b1;
		fork
			reset_check();
			mfp_check();
		join
		run_vectors();
		irq_check();
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- test/st_glue_vectors.txt
# name kind a b c exp_l exp_r, all hex
# time: a=time word, wr: a=reg b=data, rd: a=reg exp_l=data, audio: a=ym b=dma_l c=dma_r
t_set time 3451228193756 0 0 0 0
rd_r0 rd 0 0 0 6 0
rd_r1 rd 1 0 0 5 0
rd_r2 rd 2 0 0 7 0
rd_r3 rd 3 0 0 3 0
rd_r4 rd 4 0 0 9 0
rd_r5 rd 5 0 0 1 0
rd_r6 rd 6 0 0 3 0
rd_r7 rd 7 0 0 8 0
rd_r8 rd 8 0 0 2 0
rd_r9 rd 9 0 0 2 0
rd_r10 rd a 0 0 1 0
rd_r11 rd b 0 0 4 0
rd_year rd c 0 0 7 0
rd_mode rd d 0 0 8 0
yw_set time 00f0000000001 0 0 0 0
yw_r0 rd 0 0 0 1 0
yw_year rd c 0 0 1 0
z_set time 0 0 0 0 0
z_r0 rd 0 0 0 f 0
z_mode rd d 0 0 f 0
t_back time 3451228193756 0 0 0 0
wr_r0 wr 0 a 0 0 0
wr_r5 wr 5 3 0 0 0
wr_year wr c e 0 0 0
wr_bank1 wr d 1 0 0 0
b1_r0 rd 0 0 0 a 0
b1_r5 rd 5 0 0 3 0
b1_year rd c 0 0 e 0
b1_mode rd d 0 0 9 0
b1_test rd e 0 0 0 0
b1_rst rd f 0 0 c 0
wr_bank0 wr d 0 0 0 0
b0_r0 rd 0 0 0 6 0
au_mid audio 200 80 80 0 0
au_max audio 3ff ff 80 3fd6 1ff7
au_min audio 0 0 ff 4028 7fe7
au_mix audio 100 40 80 603c 700c

//--- files.f
verilog/st_glue_pkg.sv
verilog/st_reset_seq.sv
verilog/mfp_clk_gen.sv
verilog/snd_irq_delay.sv
verilog/rtc_rp5c15.sv
verilog/audio_mix.sv
verilog/st_glue_top.sv
test/st_glue_props.sv
test/st_glue_tb.sv

//--- Bender.yml
package:
  name: st_glue

sources:
  - verilog/st_glue_pkg.sv
  - verilog/st_reset_seq.sv
  - verilog/mfp_clk_gen.sv
  - verilog/snd_irq_delay.sv
  - verilog/rtc_rp5c15.sv
  - verilog/audio_mix.sv
  - verilog/st_glue_top.sv
  - target: test
    files:
      - test/st_glue_props.sv
      - test/st_glue_tb.sv
